//--- vec_pkg.sv
package vec_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////////

  localparam int unsigned NrLanes      = 4;
  localparam int unsigned ElemWidth    = 32;
  localparam int unsigned MaxVl        = 16;
  localparam int unsigned ElemsPerLane = MaxVl / NrLanes;
  localparam int unsigned NrVRegs      = 8;
  // Lanes first, then the load/store unit at index NrLanes
  localparam int unsigned NrPEs        = NrLanes + 1;
  localparam int unsigned AddrWidth    = 16;
  // Scoreboard depth
  localparam int unsigned NrVInsn      = 4;

  typedef logic [ElemWidth-1:0]             elem_t;
  typedef logic [2:0]                       vreg_t;
  typedef logic [4:0]                       vl_t;
  typedef logic [$clog2(NrVInsn)-1:0]       vid_t;
  typedef logic [$clog2(NrLanes)-1:0]       lane_idx_t;
  typedef logic [$clog2(ElemsPerLane)-1:0]  slot_t;

  // Code 3'd7 is reserved
  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VXOR  = 3'd3,
    VLE   = 3'd4,
    VSE   = 3'd5,
    VMVXS = 3'd6
  } vop_e;

  // VSE stores vd, VMVXS reads element 0 of vs2
  typedef struct packed {
    vop_e                 op;
    vreg_t                vd;
    vreg_t                vs1;
    vreg_t                vs2;
    vl_t                  vl;
    logic [AddrWidth-1:0] base;
  } vinsn_t;

  //////////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////////

  function automatic logic is_mem_op(vinsn_t insn);
    return insn.op inside {VLE, VSE};
  endfunction

  function automatic logic [NrVRegs-1:0] reads_regs(vinsn_t insn);
    logic [NrVRegs-1:0] rset;
    rset = '0;
    case (insn.op)
      VADD, VSUB, VAND, VXOR: begin
        rset[insn.vs1] = 1'b1;
        rset[insn.vs2] = 1'b1;
      end
      VSE:     rset[insn.vd]  = 1'b1;
      VMVXS:   rset[insn.vs2] = 1'b1;
      default: rset = '0;
    endcase
    return rset;
  endfunction

  function automatic logic [NrVRegs-1:0] writes_reg(vinsn_t insn);
    logic [NrVRegs-1:0] wset;
    wset = '0;
    if (insn.op inside {VADD, VSUB, VAND, VXOR, VLE}) begin
      wset[insn.vd] = 1'b1;
    end
    return wset;
  endfunction

  // Processing elements that take part in an instruction
  function automatic logic [NrPEs-1:0] pe_targets(vinsn_t insn);
    logic [NrPEs-1:0] tgt;
    tgt = '0;
    if (is_mem_op(insn)) begin
      tgt[NrLanes] = 1'b1;
    end else if (insn.op == VMVXS) begin
      tgt[0] = 1'b1;
    end else begin
      tgt[NrLanes-1:0] = '1;
    end
    return tgt;
  endfunction

  function automatic lane_idx_t lane_of(vl_t idx);
    return lane_idx_t'(idx % NrLanes);
  endfunction

  function automatic slot_t slot_of(vl_t idx);
    return slot_t'(idx / NrLanes);
  endfunction

endpackage

//--- vec_pe_if.sv
`timescale 1ns/1ps

interface vec_pe_if;
  import vec_pkg::*;

  // Issue side
  logic             req_valid;
  vinsn_t           req;
  vid_t             req_id;

  // One bit per processing element
  logic [NrPEs-1:0] ready;
  logic [NrPEs-1:0] done;

  // Scalar result of VMVXS, lane 0 only
  logic             scalar_valid;
  elem_t            scalar;

  modport seq (
    output req_valid, req, req_id,
    input  ready, done, scalar_valid, scalar
  );

  modport pe (
    input  req_valid, req, req_id,
    output ready, done, scalar_valid, scalar
  );

endinterface

//--- vec_lane_mem_if.sv
`timescale 1ns/1ps

interface vec_lane_mem_if;
  import vec_pkg::*;

  // Store operand reads, data one cycle later
  logic  [NrLanes-1:0] rd_req;
  vreg_t               rd_reg;
  slot_t               rd_slot;
  elem_t [NrLanes-1:0] rd_data;

  // Load result writes
  logic  [NrLanes-1:0] wr_req;
  vreg_t               wr_reg;
  slot_t               wr_slot;
  elem_t               wr_data;

  modport lsu (
    output rd_req, rd_reg, rd_slot, wr_req, wr_reg, wr_slot, wr_data,
    input  rd_data
  );

  modport lane (
    input  rd_req, rd_reg, rd_slot, wr_req, wr_reg, wr_slot, wr_data,
    output rd_data
  );

endinterface

//--- vec_dispatcher.sv
`timescale 1ns/1ps

module vec_dispatcher (
  input  logic             clk_i,
  input  logic             rst_i,
  // Scalar core side
  input  logic             insn_valid_i,
  input  vec_pkg::vinsn_t  insn_i,
  output logic             insn_ready_o,
  output logic             resp_valid_o,
  output logic             resp_error_o,
  output vec_pkg::elem_t   resp_scalar_o,
  // Sequencer side
  output logic             seq_valid_o,
  output vec_pkg::vinsn_t  seq_insn_o,
  input  logic             seq_ready_i,
  input  logic             seq_scalar_valid_i,
  input  vec_pkg::elem_t   seq_scalar_i
);
  import vec_pkg::*;

  logic   full_q;
  logic   fwd_done_q;
  vinsn_t insn_q;
  logic   legal;
  logic   fwd;

  // Zero length, overlong or reserved opcode
  assign legal = (insn_q.vl != '0) && (insn_q.vl <= vl_t'(MaxVl)) &&
                 (insn_q.op inside {VADD, VSUB, VAND, VXOR, VLE, VSE, VMVXS});

  assign insn_ready_o = !full_q;
  assign seq_valid_o  = full_q && legal && !fwd_done_q;
  assign seq_insn_o   = insn_q;
  assign fwd          = seq_valid_o && seq_ready_i;

  // VMVXS answers once lane 0 has read the element
  assign resp_valid_o  = full_q && (!legal || (fwd && insn_q.op != VMVXS) ||
                                    (fwd_done_q && seq_scalar_valid_i));
  assign resp_error_o  = full_q && !legal;
  assign resp_scalar_o = seq_scalar_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q     <= 1'b0;
      fwd_done_q <= 1'b0;
    end else begin
      if (insn_valid_i && insn_ready_o) begin
        full_q <= 1'b1;
      end else if (resp_valid_o) begin
        full_q     <= 1'b0;
        fwd_done_q <= 1'b0;
      end
      if (fwd && insn_q.op == VMVXS) begin
        fwd_done_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (insn_valid_i && insn_ready_o) begin
      insn_q <= insn_i;
    end
  end

  a_fwd_offered: assert property (@(posedge clk_i) disable iff (rst_i)
    seq_ready_i |-> seq_valid_o)
    else $error("Sequencer took an instruction that was not offered");

endmodule

//--- vec_sequencer.sv
`timescale 1ns/1ps

module vec_sequencer (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             insn_valid_i,
  input  vec_pkg::vinsn_t  insn_i,
  output logic             insn_ready_o,
  output logic             scalar_valid_o,
  output vec_pkg::elem_t   scalar_o,
  output logic             idle_o,
  vec_pe_if.seq            pe
);
  import vec_pkg::*;

  // Outstanding done bits per tag
  // An entry is live while any of its bits is set
  logic [NrVInsn-1:0][NrPEs-1:0]   pend_q;
  logic [NrVInsn-1:0][NrPEs-1:0]   pend_d;
  logic [NrVInsn-1:0][NrVRegs-1:0] rd_set_q;
  logic [NrVInsn-1:0][NrVRegs-1:0] wr_set_q;
  // Tag each processing element is working on
  vid_t [NrPEs-1:0]                pe_id_q;
  // Done bit each element still owes to its current tag
  logic [NrPEs-1:0]                pend_own;
  logic [NrVInsn-1:0]              busy;
  logic                            req_valid_q;

  logic [NrVRegs-1:0] rd_new;
  logic [NrVRegs-1:0] wr_new;
  logic [NrPEs-1:0]   target;
  logic               conflict;
  logic               sb_full;
  vid_t               free_id;
  logic               issue;

  assign rd_new = reads_regs(insn_i);
  assign wr_new = writes_reg(insn_i);
  assign target = pe_targets(insn_i);

  //////////////////////////////////////////////////////////////////////////
  // Scoreboard
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    conflict = 1'b0;
    sb_full  = 1'b1;
    free_id  = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      busy[i] = |pend_q[i];
      if (busy[i]) begin
        // RAW, WAW and WAR against running instructions
        conflict |= (|((rd_new | wr_new) & wr_set_q[i])) | (|(wr_new & rd_set_q[i]));
      end else begin
        sb_full = 1'b0;
        free_id = vid_t'(i);
      end
    end
  end

  always_comb begin
    pend_d = pend_q;
    for (int p = 0; p < NrPEs; p++) begin
      if (pe.done[p]) begin
        pend_d[pe_id_q[p]][p] = 1'b0;
      end
    end
    if (issue) begin
      pend_d[free_id] = target;
    end
  end

  always_comb begin
    for (int p = 0; p < NrPEs; p++) begin
      pend_own[p] = pend_q[pe_id_q[p]][p];
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Issue
  //////////////////////////////////////////////////////////////////////////

  assign issue        = req_valid_q && (&(pe.ready | ~target));
  assign insn_ready_o = issue;

  assign pe.req_valid = req_valid_q;
  assign pe.req       = insn_i;
  assign pe.req_id    = free_id;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q      <= '0;
      req_valid_q <= 1'b0;
    end else begin
      pend_q <= pend_d;
      // Entries only retire while waiting so a clear check stays clear
      req_valid_q <= insn_valid_i && !issue && !conflict && !sb_full;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      rd_set_q[free_id] <= rd_new;
      wr_set_q[free_id] <= wr_new;
      for (int p = 0; p < NrPEs; p++) begin
        if (target[p]) begin
          pe_id_q[p] <= free_id;
        end
      end
    end
  end

  assign scalar_valid_o = pe.scalar_valid;
  assign scalar_o       = pe.scalar;
  assign idle_o         = !(|busy) && !insn_valid_i;

  a_done_owed: assert property (@(posedge clk_i) disable iff (rst_i)
    (pe.done & ~pend_own) == '0)
    else $error("A done pulse arrived for a tag that was no longer in flight");

endmodule

//--- vec_lane.sv
`timescale 1ns/1ps

module vec_lane #(
  parameter int unsigned LaneId = 0
) (
  input  logic         clk_i,
  input  logic         rst_i,
  vec_pe_if.pe         pe,
  vec_lane_mem_if.lane mem
);
  import vec_pkg::*;

  // Slice of the register file
  // Element i sits at slot i div NrLanes
  elem_t            vrf_q [NrVRegs][ElemsPerLane];

  logic             busy_q;
  logic             done_q;
  slot_t            slot_q;
  vinsn_t           insn_q;
  elem_t            rd_data_q;

  logic [NrPEs-1:0] tgt;
  logic             accept;
  vl_t              elem_idx;
  vl_t              next_idx;
  logic             last;
  logic             alu_we;
  logic             stall;
  elem_t            op_a;
  elem_t            op_b;
  elem_t            result;

  assign tgt    = pe_targets(pe.req);
  assign accept = pe.req_valid && (&(pe.ready | ~tgt)) && tgt[LaneId];

  assign pe.ready[LaneId] = !busy_q;
  assign pe.done[LaneId]  = done_q;

  //////////////////////////////////////////////////////////////////////////
  // Element walk
  //////////////////////////////////////////////////////////////////////////

  assign elem_idx = vl_t'(slot_q * NrLanes + LaneId);
  assign next_idx = elem_idx + vl_t'(NrLanes);
  assign last     = (insn_q.op == VMVXS) || (slot_q == slot_t'(ElemsPerLane - 1)) ||
                    (next_idx >= insn_q.vl);

  // Load writes take the port and the ALU retries the same slot
  assign alu_we = busy_q && (insn_q.op != VMVXS) && (elem_idx < insn_q.vl);
  assign stall  = alu_we && mem.wr_req[LaneId];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      slot_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (accept) begin
        busy_q <= 1'b1;
        slot_q <= '0;
      end else if (busy_q && !stall) begin
        if (last) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end else begin
          slot_q <= slot_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= pe.req;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // ALU and register file ports
  //////////////////////////////////////////////////////////////////////////

  assign op_a = vrf_q[insn_q.vs1][slot_q];
  assign op_b = vrf_q[insn_q.vs2][slot_q];

  always_comb begin
    case (insn_q.op)
      VADD:    result = op_b + op_a;
      // vs2 minus vs1
      VSUB:    result = op_b - op_a;
      VAND:    result = op_b & op_a;
      VXOR:    result = op_b ^ op_a;
      default: result = op_b;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (mem.wr_req[LaneId]) begin
      vrf_q[mem.wr_reg][mem.wr_slot] <= mem.wr_data;
    end else if (alu_we) begin
      vrf_q[insn_q.vd][slot_q] <= result;
    end
  end

  // Store operand port holds its value until the next read
  always_ff @(posedge clk_i) begin
    if (mem.rd_req[LaneId]) begin
      rd_data_q <= vrf_q[mem.rd_reg][mem.rd_slot];
    end
  end

  assign mem.rd_data[LaneId] = rd_data_q;

  // VMVXS reads slot 0 of vs2 in its only busy cycle
  if (LaneId == 0) begin : gen_scalar
    assign pe.scalar_valid = busy_q && (insn_q.op == VMVXS);
    assign pe.scalar       = op_b;
  end

  a_alu_retry: assert property (@(posedge clk_i) disable iff (rst_i)
    stall |=> alu_we && slot_q == $past(slot_q) && !mem.wr_req[LaneId])
    else $error("Lane %0d dropped an ALU write on a load collision", LaneId);

endmodule

//--- vec_lsu.sv
`timescale 1ns/1ps

module vec_lsu (
  input  logic                          clk_i,
  input  logic                          rst_i,
  vec_pe_if.pe                          pe,
  vec_lane_mem_if.lsu                   lanes,
  // Word memory port
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [vec_pkg::AddrWidth-1:0] mem_addr_o,
  output vec_pkg::elem_t                mem_wdata_o,
  input  logic                          mem_gnt_i,
  input  vec_pkg::elem_t                mem_rdata_i
);
  import vec_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_READ,
    S_REQ,
    S_LOAD
  } state_e;

  state_e           state_q;
  vinsn_t           insn_q;
  vl_t              idx_q;
  logic             done_q;

  logic [NrPEs-1:0] tgt;
  logic             accept;
  logic             last;
  lane_idx_t        cur_lane;

  assign tgt    = pe_targets(pe.req);
  assign accept = pe.req_valid && (&(pe.ready | ~tgt)) && tgt[NrLanes];

  assign pe.ready[NrLanes] = (state_q == S_IDLE);
  assign pe.done[NrLanes]  = done_q;

  assign last     = (idx_q == insn_q.vl - vl_t'(1));
  assign cur_lane = lane_of(idx_q);

  //////////////////////////////////////////////////////////////////////////
  // Lane side
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    lanes.rd_req = '0;
    lanes.wr_req = '0;
    if (state_q == S_READ) begin
      lanes.rd_req[cur_lane] = 1'b1;
    end
    // Read data of the load arrives in this state
    if (state_q == S_LOAD) begin
      lanes.wr_req[cur_lane] = 1'b1;
    end
  end

  assign lanes.rd_reg  = insn_q.vd;
  assign lanes.rd_slot = slot_of(idx_q);
  assign lanes.wr_reg  = insn_q.vd;
  assign lanes.wr_slot = slot_of(idx_q);
  assign lanes.wr_data = mem_rdata_i;

  //////////////////////////////////////////////////////////////////////////
  // Memory side
  //////////////////////////////////////////////////////////////////////////

  assign mem_req_o   = (state_q == S_REQ);
  assign mem_we_o    = (insn_q.op == VSE);
  assign mem_addr_o  = insn_q.base + AddrWidth'(idx_q);
  // Lane read register keeps the operand until the next read request
  assign mem_wdata_o = lanes.rd_data[cur_lane];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      idx_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (accept) begin
            idx_q   <= '0;
            state_q <= (pe.req.op == VSE) ? S_READ : S_REQ;
          end
        end
        S_READ: state_q <= S_REQ;
        S_REQ: begin
          if (mem_gnt_i) begin
            if (insn_q.op != VSE) begin
              state_q <= S_LOAD;
            end else if (last) begin
              done_q  <= 1'b1;
              state_q <= S_IDLE;
            end else begin
              idx_q   <= idx_q + vl_t'(1);
              state_q <= S_READ;
            end
          end
        end
        default: begin
          if (last) begin
            done_q  <= 1'b1;
            state_q <= S_IDLE;
          end else begin
            idx_q   <= idx_q + vl_t'(1);
            state_q <= S_REQ;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= pe.req;
    end
  end

  a_req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_o && !mem_gnt_i |=>
      mem_req_o && $stable({mem_we_o, mem_addr_o, mem_wdata_o}))
    else $error("Memory request changed before its grant");

endmodule

//--- vec_top.sv
`timescale 1ns/1ps

module vec_top (
  input  logic                          clk_i,
  input  logic                          rst_i,
  // Scalar core
  input  logic                          insn_valid_i,
  input  vec_pkg::vinsn_t               insn_i,
  output logic                          insn_ready_o,
  output logic                          resp_valid_o,
  output logic                          resp_error_o,
  output vec_pkg::elem_t                resp_scalar_o,
  output logic                          idle_o,
  // Memory
  output logic                          mem_req_o,
  output logic                          mem_we_o,
  output logic [vec_pkg::AddrWidth-1:0] mem_addr_o,
  output vec_pkg::elem_t                mem_wdata_o,
  input  logic                          mem_gnt_i,
  input  vec_pkg::elem_t                mem_rdata_i
);
  import vec_pkg::*;

  // Dispatcher to sequencer
  logic   seq_valid;
  vinsn_t seq_insn;
  logic   seq_ready;
  logic   seq_scalar_valid;
  elem_t  seq_scalar;

  vec_pe_if       pe_if ();
  vec_lane_mem_if lane_mem_if ();

  vec_dispatcher i_dispatcher (
    .clk_i             (clk_i           ),
    .rst_i             (rst_i           ),
    .insn_valid_i      (insn_valid_i    ),
    .insn_i            (insn_i          ),
    .insn_ready_o      (insn_ready_o    ),
    .resp_valid_o      (resp_valid_o    ),
    .resp_error_o      (resp_error_o    ),
    .resp_scalar_o     (resp_scalar_o   ),
    .seq_valid_o       (seq_valid       ),
    .seq_insn_o        (seq_insn        ),
    .seq_ready_i       (seq_ready       ),
    .seq_scalar_valid_i(seq_scalar_valid),
    .seq_scalar_i      (seq_scalar      )
  );

  vec_sequencer i_sequencer (
    .clk_i         (clk_i           ),
    .rst_i         (rst_i           ),
    .insn_valid_i  (seq_valid       ),
    .insn_i        (seq_insn        ),
    .insn_ready_o  (seq_ready       ),
    .scalar_valid_o(seq_scalar_valid),
    .scalar_o      (seq_scalar      ),
    .idle_o        (idle_o          ),
    .pe            (pe_if.seq       )
  );

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane #(
      .LaneId(l)
    ) i_lane (
      .clk_i(clk_i           ),
      .rst_i(rst_i           ),
      .pe   (pe_if.pe        ),
      .mem  (lane_mem_if.lane)
    );
  end

  vec_lsu i_lsu (
    .clk_i      (clk_i          ),
    .rst_i      (rst_i          ),
    .pe         (pe_if.pe       ),
    .lanes      (lane_mem_if.lsu),
    .mem_req_o  (mem_req_o      ),
    .mem_we_o   (mem_we_o       ),
    .mem_addr_o (mem_addr_o     ),
    .mem_wdata_o(mem_wdata_o    ),
    .mem_gnt_i  (mem_gnt_i      ),
    .mem_rdata_i(mem_rdata_i    )
  );

endmodule

//--- tb_vec.sv
`timescale 1ns/1ps

module tb_vec;
  import vec_pkg::*;

  localparam int unsigned TimeoutCycles = 1000;

  // Memory regions, one vector each
  localparam logic [AddrWidth-1:0] RegionA    = 16'h0100;
  localparam logic [AddrWidth-1:0] RegionB    = 16'h0200;
  localparam logic [AddrWidth-1:0] RegionC    = 16'h0300;
  localparam logic [AddrWidth-1:0] RegionSum  = 16'h0400;
  localparam logic [AddrWidth-1:0] RegionDiff = 16'h0500;
  localparam logic [AddrWidth-1:0] RegionAnd  = 16'h0600;
  localparam logic [AddrWidth-1:0] RegionXor  = 16'h0700;
  localparam logic [AddrWidth-1:0] RegionPart = 16'h0800;
  localparam logic [AddrWidth-1:0] RegionIll  = 16'h0900;

  logic                 clk_i = 1'b0;
  logic                 rst_i;
  logic                 insn_valid_i;
  vinsn_t               insn_i;
  logic                 insn_ready_o;
  logic                 resp_valid_o;
  logic                 resp_error_o;
  elem_t                resp_scalar_o;
  logic                 idle_o;
  logic                 mem_req_o;
  logic                 mem_we_o;
  logic [AddrWidth-1:0] mem_addr_o;
  elem_t                mem_wdata_o;
  logic                 mem_gnt_i = 1'b0;
  elem_t                mem_rdata_i = '0;

  elem_t                mem_model [2**AddrWidth];
  logic [31:0]          rng_state = 32'd29973;
  int unsigned          gnt_wait = 0;
  logic                 gnt_armed = 1'b0;
  int unsigned          req_cycles = 0;
  int unsigned          error_count = 0;
  int unsigned          timeout_count = 0;
  // Expected register contents, element i at index i
  elem_t                exp_vreg [NrVRegs][MaxVl];

  vec_top uut (
    .clk_i        (clk_i        ),
    .rst_i        (rst_i        ),
    .insn_valid_i (insn_valid_i ),
    .insn_i       (insn_i       ),
    .insn_ready_o (insn_ready_o ),
    .resp_valid_o (resp_valid_o ),
    .resp_error_o (resp_error_o ),
    .resp_scalar_o(resp_scalar_o),
    .idle_o       (idle_o       ),
    .mem_req_o    (mem_req_o    ),
    .mem_we_o     (mem_we_o     ),
    .mem_addr_o   (mem_addr_o   ),
    .mem_wdata_o  (mem_wdata_o  ),
    .mem_gnt_i    (mem_gnt_i    ),
    .mem_rdata_i  (mem_rdata_i  )
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] s;
    s = x;
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  function automatic elem_t fill_word(logic [AddrWidth-1:0] addr);
    return {~addr, addr};
  endfunction

  function automatic vinsn_t make_insn(vop_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, vl_t vl,
                                       logic [AddrWidth-1:0] base);
    vinsn_t insn;
    insn.op   = op;
    insn.vd   = vd;
    insn.vs1  = vs1;
    insn.vs2  = vs2;
    insn.vl   = vl;
    insn.base = base;
    return insn;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  // Grant after 0 to 3 extra cycles, read data in the cycle after the grant
  always @(posedge clk_i) begin
    if (rst_i) begin
      mem_gnt_i <= 1'b0;
      gnt_armed = 1'b0;
      for (int a = 0; a < 2**AddrWidth; a++) begin
        mem_model[a] = fill_word(AddrWidth'(a));
      end
      // Operand regions get random data
      for (int i = 0; i < MaxVl; i++) begin
        rng_state = xorshift32(rng_state);
        mem_model[RegionA + AddrWidth'(i)] = rng_state;
        rng_state = xorshift32(rng_state);
        mem_model[RegionC + AddrWidth'(i)] = rng_state;
      end
    end else begin
      if (mem_req_o) begin
        req_cycles++;
      end
      if (mem_gnt_i) begin
        // The request is taken at this edge
        mem_gnt_i <= 1'b0;
        assert (mem_req_o) else begin
          $display("Memory grant was given while no request was pending");
          error_count++;
        end
        if (mem_we_o) begin
          mem_model[mem_addr_o] = mem_wdata_o;
        end else begin
          mem_rdata_i <= mem_model[mem_addr_o];
        end
      end else if (mem_req_o) begin
        if (!gnt_armed) begin
          rng_state = xorshift32(rng_state);
          gnt_wait  = rng_state % 4;
          gnt_armed = 1'b1;
        end
        if (gnt_wait == 0) begin
          mem_gnt_i <= 1'b1;
          gnt_armed = 1'b0;
        end else begin
          gnt_wait--;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Driving and checking
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string name, input elem_t expected, input elem_t actual);
    assert (actual === expected) else begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  // Memory words against the expected register contents
  task automatic check_words(input string name, input logic [AddrWidth-1:0] base,
                             input int unsigned vreg, input int unsigned count);
    if (timeout_count != 0) return;
    for (int i = 0; i < count; i++) begin
      check_value($sformatf("%s word %0d", name, i), exp_vreg[vreg][i],
                  mem_model[base + AddrWidth'(i)]);
    end
  endtask

  // Called at a rising edge, returns at a rising edge
  task automatic run_insn(input string name, input vinsn_t insn,
                          output logic err, output elem_t scalar);
    int unsigned cycles;
    logic        accepted;
    logic        answered;
    err      = 1'b0;
    scalar   = '0;
    accepted = 1'b0;
    answered = 1'b0;
    cycles   = 0;
    if (timeout_count != 0) return;
    insn_valid_i <= 1'b1;
    insn_i       <= insn;
    while (!accepted && cycles < TimeoutCycles) begin
      @(posedge clk_i);
      accepted = insn_ready_o;
      cycles++;
    end
    insn_valid_i <= 1'b0;
    if (!accepted) begin
      $display("Timeout in %s: the instruction was never accepted", name);
      timeout_count++;
      return;
    end
    cycles = 0;
    while (!answered && cycles < TimeoutCycles) begin
      @(posedge clk_i);
      if (resp_valid_o) begin
        answered = 1'b1;
        err      = resp_error_o;
        scalar   = resp_scalar_o;
      end
      cycles++;
    end
    if (!answered) begin
      $display("Timeout in %s: no response arrived", name);
      timeout_count++;
    end
  endtask

  task automatic wait_idle(input string name);
    int unsigned cycles;
    logic        idle;
    cycles = 0;
    idle   = 1'b0;
    if (timeout_count != 0) return;
    while (!idle && cycles < TimeoutCycles) begin
      @(posedge clk_i);
      idle = idle_o;
      assert (!resp_valid_o) else begin
        $display("%s: a response came with no instruction pending", name);
        error_count++;
      end
      cycles++;
    end
    if (!idle) begin
      $display("Timeout in %s: the coprocessor never went idle", name);
      timeout_count++;
    end
  endtask

  task automatic issue_legal(input string name, input vinsn_t insn);
    logic  err;
    elem_t scalar;
    run_insn(name, insn, err, scalar);
    if (timeout_count == 0) begin
      check_value({name, " error flag"}, 0, 32'(err));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    check_value("reset resp_valid_o", 0, 32'(resp_valid_o));
    check_value("reset mem_req_o", 0, 32'(mem_req_o));
    check_value("reset insn_ready_o", 1, 32'(insn_ready_o));
    check_value("reset idle_o", 1, 32'(idle_o));
  endtask

  task automatic test_load_store();
    for (int i = 0; i < MaxVl; i++) begin
      exp_vreg[1][i] = mem_model[RegionA + AddrWidth'(i)];
    end
    issue_legal("load_store vle", make_insn(VLE, 3'd1, 3'd0, 3'd0, 5'd16, RegionA));
    issue_legal("load_store vse", make_insn(VSE, 3'd1, 3'd0, 3'd0, 5'd16, RegionB));
    wait_idle("load_store");
    check_words("load_store", RegionB, 1, MaxVl);
  endtask

  task automatic test_arith();
    for (int i = 0; i < MaxVl; i++) begin
      exp_vreg[2][i] = mem_model[RegionC + AddrWidth'(i)];
      // Second operand minus first, all modulo 2**32
      exp_vreg[3][i] = exp_vreg[2][i] + exp_vreg[1][i];
      exp_vreg[4][i] = exp_vreg[2][i] - exp_vreg[1][i];
      exp_vreg[5][i] = exp_vreg[2][i] & exp_vreg[1][i];
      exp_vreg[6][i] = exp_vreg[2][i] ^ exp_vreg[1][i];
    end
    // No idle wait in between, the scoreboard orders them
    issue_legal("arith vle", make_insn(VLE, 3'd2, 3'd0, 3'd0, 5'd16, RegionC));
    issue_legal("arith vadd", make_insn(VADD, 3'd3, 3'd1, 3'd2, 5'd16, '0));
    issue_legal("arith vsub", make_insn(VSUB, 3'd4, 3'd1, 3'd2, 5'd16, '0));
    issue_legal("arith vand", make_insn(VAND, 3'd5, 3'd1, 3'd2, 5'd16, '0));
    issue_legal("arith vxor", make_insn(VXOR, 3'd6, 3'd1, 3'd2, 5'd16, '0));
    issue_legal("arith store sum", make_insn(VSE, 3'd3, 3'd0, 3'd0, 5'd16, RegionSum));
    issue_legal("arith store diff", make_insn(VSE, 3'd4, 3'd0, 3'd0, 5'd16, RegionDiff));
    issue_legal("arith store and", make_insn(VSE, 3'd5, 3'd0, 3'd0, 5'd16, RegionAnd));
    issue_legal("arith store xor", make_insn(VSE, 3'd6, 3'd0, 3'd0, 5'd16, RegionXor));
    wait_idle("arith");
    check_words("arith vadd", RegionSum, 3, MaxVl);
    check_words("arith vsub", RegionDiff, 4, MaxVl);
    check_words("arith vand", RegionAnd, 5, MaxVl);
    check_words("arith vxor", RegionXor, 6, MaxVl);
  endtask

  task automatic test_partial();
    issue_legal("partial vse", make_insn(VSE, 3'd3, 3'd0, 3'd0, 5'd7, RegionPart));
    wait_idle("partial");
    check_words("partial", RegionPart, 3, 7);
    if (timeout_count == 0) begin
      // Words past the length keep the fill pattern
      for (int i = 7; i < MaxVl + 4; i++) begin
        check_value($sformatf("partial untouched word %0d", i),
                    fill_word(RegionPart + AddrWidth'(i)), mem_model[RegionPart + AddrWidth'(i)]);
      end
    end
  endtask

  task automatic test_scalar();
    logic  err;
    elem_t scalar;
    for (int r = 4; r <= 5; r++) begin
      run_insn("scalar vmvxs", make_insn(VMVXS, 3'd0, 3'd0, vreg_t'(r), 5'd1, '0), err, scalar);
      if (timeout_count == 0) begin
        check_value($sformatf("scalar v%0d error flag", r), 0, 32'(err));
        check_value($sformatf("scalar v%0d element 0", r), exp_vreg[r][0], scalar);
      end
      wait_idle("scalar");
    end
  endtask

  task automatic test_illegal();
    logic        err;
    elem_t       scalar;
    int unsigned req_before;
    vinsn_t      bad [3];
    req_before = req_cycles;
    // Each would overwrite v1 if it ran
    bad[0] = make_insn(VLE, 3'd1, 3'd0, 3'd0, 5'd0, RegionC);
    bad[1] = make_insn(VADD, 3'd1, 3'd2, 3'd2, 5'd17, '0);
    bad[2] = make_insn(vop_e'(3'd7), 3'd1, 3'd2, 3'd2, 5'd16, RegionC);
    for (int k = 0; k < 3; k++) begin
      run_insn("illegal", bad[k], err, scalar);
      if (timeout_count == 0) begin
        check_value($sformatf("illegal case %0d error flag", k), 1, 32'(err));
      end
      wait_idle("illegal");
    end
    check_value("illegal memory request cycles", req_before, req_cycles);
    issue_legal("illegal vse", make_insn(VSE, 3'd1, 3'd0, 3'd0, 5'd16, RegionIll));
    wait_idle("illegal");
    check_words("illegal register v1", RegionIll, 1, MaxVl);
  endtask

  initial begin
    rst_i        = 1'b1;
    insn_valid_i = 1'b0;
    insn_i       = '0;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b0;
    @(posedge clk_i);

    test_reset();
    test_load_store();
    test_arith();
    test_partial();
    test_scalar();
    test_illegal();

    $display("Run finished with %0d errors and %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
vec_pkg.sv
vec_pe_if.sv
vec_lane_mem_if.sv
vec_dispatcher.sv
vec_sequencer.sv
vec_lane.sv
vec_lsu.sv
vec_top.sv
tb_vec.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vec
RTL_TOP   ?= vec_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS := vec_pkg.sv vec_pe_if.sv vec_lane_mem_if.sv vec_dispatcher.sv \
            vec_sequencer.sv vec_lane.sv vec_lsu.sv vec_top.sv
TB_SRCS  := tb_vec.sv
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(RTL_SRCS) $(TB_SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "TEST OK" $(LOG) || { echo "No pass line found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
